// ==== hdl/fpga_mem_controller.sv ====
`timescale 1ns/1ps

module fpga_mem_controller (
    input  logic                             clk,
    input  logic                             rst,

    // Cache side
    input  logic [fpga_mem_pkg::ADDR_W-1:0]  bmem_addr,
    input  logic                             bmem_read,
    input  logic                             bmem_write,
    input  logic [fpga_mem_pkg::LINE_W-1:0]  bmem_wdata,
    output logic                             bmem_ready,
    output logic [fpga_mem_pkg::ADDR_W-1:0]  bmem_raddr,
    output logic [fpga_mem_pkg::LINE_W-1:0]  bmem_rdata,
    output logic                             bmem_rvalid,

    // Memory link
    output fpga_mem_pkg::link_c2m_t          link_out,
    input  fpga_mem_pkg::link_m2c_t          link_in
);

    typedef enum logic [3:0] {
        IDLE,
        READ_ADDR,
        READ_DATA_1,
        READ_DATA_2,
        READ_DONE,
        WRITE_ADDR,
        WRITE_DATA_1,
        WRITE_DATA_2,
        WRITE_DONE
    } state_t;

    state_t state;
    state_t state_next;

    logic                            accept;
    logic [fpga_mem_pkg::ADDR_W-1:0] req_addr;
    fpga_mem_pkg::line_u             wline;
    fpga_mem_pkg::line_u             rline;

    assign bmem_ready  = (state == IDLE);
    assign accept      = bmem_ready && (bmem_read || bmem_write);
    assign bmem_raddr  = req_addr;
    assign bmem_rdata  = rline.raw;
    // Whole line is in rline once the second beat has landed
    assign bmem_rvalid = (state == READ_DONE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Request latch and read assembly
    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr  <= bmem_addr;
            wline.raw <= bmem_wdata;
        end
        if (state == READ_DATA_1 && link_in.resp) begin
            rline.beats.lo <= link_in.bus;
        end
        if (state == READ_DATA_2 && link_in.resp) begin
            rline.beats.hi <= link_in.bus;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                // Read wins over write
                if (bmem_read) begin
                    state_next = READ_ADDR;
                end else if (bmem_write) begin
                    state_next = WRITE_ADDR;
                end
            end
            READ_ADDR: begin
                if (link_in.resp) begin
                    state_next = READ_DATA_1;
                end
            end
            READ_DATA_1: begin
                if (link_in.resp) begin
                    state_next = READ_DATA_2;
                end
            end
            READ_DATA_2: begin
                if (link_in.resp) begin
                    state_next = READ_DONE;
                end
            end
            READ_DONE: begin
                state_next = IDLE;
            end
            WRITE_ADDR: begin
                if (link_in.resp) begin
                    state_next = WRITE_DATA_1;
                end
            end
            WRITE_DATA_1: begin
                if (link_in.resp) begin
                    state_next = WRITE_DATA_2;
                end
            end
            WRITE_DATA_2: begin
                if (link_in.resp) begin
                    state_next = WRITE_DONE;
                end
            end
            WRITE_DONE: begin
                // Ack of the done phase closes the write
                if (link_in.resp) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    // Link phase levels follow the state directly
    always_comb begin
        link_out = '0;
        case (state)
            READ_ADDR: begin
                link_out.bus     = req_addr;
                link_out.addr_on = 1'b1;
                link_out.rd_en   = 1'b1;
            end
            READ_DATA_1, READ_DATA_2: begin
                link_out.data_on = 1'b1;
                link_out.rd_en   = 1'b1;
            end
            WRITE_ADDR: begin
                link_out.bus     = req_addr;
                link_out.addr_on = 1'b1;
                link_out.wr_en   = 1'b1;
            end
            WRITE_DATA_1: begin
                link_out.bus     = wline.beats.lo;
                link_out.data_on = 1'b1;
                link_out.wr_en   = 1'b1;
            end
            WRITE_DATA_2: begin
                link_out.bus     = wline.beats.hi;
                link_out.data_on = 1'b1;
                link_out.wr_en   = 1'b1;
            end
            WRITE_DONE: begin
                link_out.wr_en   = 1'b1;
            end
            default: begin
                link_out = '0;
            end
        endcase
    end

    // Link never carries both directions at once
    a_no_rd_wr_overlap: assert property (
        @(posedge clk) disable iff (rst)
        !(link_out.rd_en && link_out.wr_en)
    );

    a_rvalid_single_pulse: assert property (
        @(posedge clk) disable iff (rst)
        bmem_rvalid |=> !bmem_rvalid
    );

endmodule

// ==== hdl/fpga_mem_pkg.sv ====
package fpga_mem_pkg;

    localparam int ADDR_W    = 32;
    localparam int WORD_W    = 32;
    localparam int LINE_W    = 64;
    localparam int RAM_WORDS = 256;

    // Two link beats of one cache line, hi in the upper bits
    typedef struct packed {
        logic [WORD_W-1:0] hi;
        logic [WORD_W-1:0] lo;
    } line_beats_t;

    // A line as one value or as two link beats
    typedef union packed {
        logic [LINE_W-1:0] raw;
        line_beats_t       beats;
    } line_u;

    // Controller to memory, address and data share bus
    typedef struct packed {
        logic [WORD_W-1:0] bus;
        logic              addr_on;
        logic              data_on;
        logic              rd_en;
        logic              wr_en;
    } link_c2m_t;

    // Memory to controller
    typedef struct packed {
        logic [WORD_W-1:0] bus;
        logic              resp;
    } link_m2c_t;

endpackage

// ==== hdl/fpga_mem_responder.sv ====
`timescale 1ns/1ps

module fpga_mem_responder #(
    parameter int RESP_DELAY = 2
) (
    input  logic                    clk,
    input  logic                    rst,
    input  fpga_mem_pkg::link_c2m_t link_in,
    output fpga_mem_pkg::link_m2c_t link_out
);

    localparam int IDX_W = $clog2(fpga_mem_pkg::RAM_WORDS);
    localparam int CNT_W = (RESP_DELAY > 0) ? $clog2(RESP_DELAY + 1) : 1;

    logic [fpga_mem_pkg::WORD_W-1:0] ram [fpga_mem_pkg::RAM_WORDS];

    logic [3:0]       en;
    logic [3:0]       en_q;
    logic             active;
    logic             resp_q;
    logic             phase_start;
    logic [CNT_W-1:0] wait_cnt;
    logic [CNT_W-1:0] cur_cnt;
    logic             resp;
    logic [IDX_W-2:0] line_idx;
    logic             beat;
    logic [IDX_W-1:0] ram_idx;
    logic             addr_ack;
    logic             wr_ack;
    logic             rd_ack;

    initial begin
        for (int i = 0; i < fpga_mem_pkg::RAM_WORDS; i++) begin
            ram[i] = '0;
        end
    end

    assign en     = {link_in.addr_on, link_in.data_on, link_in.rd_en, link_in.wr_en};
    assign active = link_in.rd_en || link_in.wr_en;

    // Back to back data beats keep the same enables, so the ack marks the boundary
    assign phase_start = active && ((en != en_q) || resp_q);
    assign cur_cnt     = phase_start ? '0 : wait_cnt;
    assign resp        = active && (cur_cnt == CNT_W'(RESP_DELAY));

    assign addr_ack = resp && link_in.addr_on;
    assign wr_ack   = resp && link_in.data_on && link_in.wr_en;
    assign rd_ack   = resp && link_in.data_on && link_in.rd_en;

    // Two words per line, wraps with the RAM depth
    assign ram_idx = {line_idx, beat};

    always_ff @(posedge clk) begin
        if (rst) begin
            en_q     <= '0;
            resp_q   <= 1'b0;
            wait_cnt <= '0;
            beat     <= 1'b0;
        end else begin
            en_q   <= en;
            resp_q <= resp;
            if (!active || resp) begin
                wait_cnt <= '0;
            end else begin
                wait_cnt <= cur_cnt + 1'b1;
            end
            if (addr_ack) begin
                beat <= 1'b0;
            end else if (wr_ack || rd_ack) begin
                beat <= ~beat;
            end
        end
    end

    // Line number from the byte address
    always_ff @(posedge clk) begin
        if (addr_ack) begin
            line_idx <= link_in.bus[3 +: IDX_W-1];
        end
    end

    always_ff @(posedge clk) begin
        if (wr_ack) begin
            ram[ram_idx] <= link_in.bus;
        end
    end

    always_comb begin
        link_out.resp = resp;
        link_out.bus  = '0;
        if (rd_ack) begin
            link_out.bus = ram[ram_idx];
        end
    end

    a_resp_needs_enable: assert property (
        @(posedge clk) disable iff (rst)
        link_out.resp |-> (link_in.rd_en || link_in.wr_en)
    );

endmodule

// ==== hdl/fpga_mem_subsystem.sv ====
`timescale 1ns/1ps

module fpga_mem_subsystem #(
    parameter int RESP_DELAY = 2
) (
    input  logic                             clk,
    input  logic                             rst,

    input  logic [fpga_mem_pkg::ADDR_W-1:0]  bmem_addr,
    input  logic                             bmem_read,
    input  logic                             bmem_write,
    input  logic [fpga_mem_pkg::LINE_W-1:0]  bmem_wdata,
    output logic                             bmem_ready,
    output logic [fpga_mem_pkg::ADDR_W-1:0]  bmem_raddr,
    output logic [fpga_mem_pkg::LINE_W-1:0]  bmem_rdata,
    output logic                             bmem_rvalid
);

    fpga_mem_pkg::link_c2m_t link_c2m;
    fpga_mem_pkg::link_m2c_t link_m2c;

    fpga_mem_controller u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .bmem_addr   (bmem_addr),
        .bmem_read   (bmem_read),
        .bmem_write  (bmem_write),
        .bmem_wdata  (bmem_wdata),
        .bmem_ready  (bmem_ready),
        .bmem_raddr  (bmem_raddr),
        .bmem_rdata  (bmem_rdata),
        .bmem_rvalid (bmem_rvalid),
        .link_out    (link_c2m),
        .link_in     (link_m2c)
    );

    // RAM model on the far side of the link
    fpga_mem_responder #(
        .RESP_DELAY (RESP_DELAY)
    ) u_resp (
        .clk      (clk),
        .rst      (rst),
        .link_in  (link_c2m),
        .link_out (link_m2c)
    );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator, pass only if the log shows the pass line

cd "$(dirname "$0")" || exit 1

TOP=tb_fpga_mem_subsystem
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
    --top-module "$TOP" \
    -Mdir "$BUILD_DIR" \
    -o "$TOP" \
    -f src.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST OK$" "$LOG"; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed, see $LOG"
exit 1

// ==== src.f ====
hdl/fpga_mem_pkg.sv
hdl/fpga_mem_controller.sv
hdl/fpga_mem_responder.sv
hdl/fpga_mem_subsystem.sv
tests/tb_fpga_mem_subsystem.sv

// ==== tests/fpga_mem_cases.txt ====
# op addr data, hex; W write, R read expecting data, B write with a read held while busy
# N one random read or write from the seeded generator, its addr and data are ignored
W 00000000 0123456789abcdef
R 00000000 0123456789abcdef
W 00000008 fedcba9876543210
R 00000008 fedcba9876543210
R 00000000 0123456789abcdef
R 00000100 0000000000000000
R 000003f8 0000000000000000
W 00000010 11111111aaaaaaaa
R 00000410 11111111aaaaaaaa
W 00000810 22222222bbbbbbbb
R 00000010 22222222bbbbbbbb
R 0000000c fedcba9876543210
W 000003f8 deadbeefcafef00d
R 000003f8 deadbeefcafef00d
R fffffff8 deadbeefcafef00d
B 00000020 0f0e0d0c0b0a0908
B 00000020 a5a5a5a55a5a5a5a
R 00000420 a5a5a5a55a5a5a5a
N 00000000 0000000000000000
N 00000000 0000000000000000
N 00000000 0000000000000000
N 00000000 0000000000000000
N 00000000 0000000000000000
N 00000000 0000000000000000
N 00000000 0000000000000000
N 00000000 0000000000000000
N 00000000 0000000000000000
N 00000000 0000000000000000
N 00000000 0000000000000000
N 00000000 0000000000000000

// ==== tests/tb_fpga_mem_subsystem.sv ====
`timescale 1ns/1ps

module tb_fpga_mem_subsystem;

    localparam int RESP_DELAY = 2;
    localparam int READ_LAT   = 1 + 3 * (RESP_DELAY + 1);
    localparam int WRITE_LAT  = 1 + 4 * (RESP_DELAY + 1);
    localparam int WAIT_LIMIT = 200;
    localparam string CASES_FILE = "tests/fpga_mem_cases.txt";

    logic        clk;
    logic        rst;
    logic [31:0] bmem_addr;
    logic        bmem_read;
    logic        bmem_write;
    logic [63:0] bmem_wdata;
    logic        bmem_ready;
    logic [31:0] bmem_raddr;
    logic [63:0] bmem_rdata;
    logic        bmem_rvalid;

    integer seed;
    int     errors;
    int     passed_cases;
    int     failed_cases;
    bit     timed_out;

    // Reference lines, keyed by wrapped line number
    logic [63:0] ref_mem [int unsigned];

    fpga_mem_subsystem #(
        .RESP_DELAY (RESP_DELAY)
    ) u_fpga_mem_subsystem (
        .clk         (clk),
        .rst         (rst),
        .bmem_addr   (bmem_addr),
        .bmem_read   (bmem_read),
        .bmem_write  (bmem_write),
        .bmem_wdata  (bmem_wdata),
        .bmem_ready  (bmem_ready),
        .bmem_raddr  (bmem_raddr),
        .bmem_rdata  (bmem_rdata),
        .bmem_rvalid (bmem_rvalid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check(input string name, input logic [63:0] exp_val,
                         input logic [63:0] act_val);
        if (exp_val !== act_val) begin
            errors++;
            $display("[ERROR] %s expected %h actual %h", name, exp_val, act_val);
        end
    endtask

    // Eight bytes per line, two RAM words per line
    function automatic int unsigned line_key(input logic [31:0] addr);
        return (addr >> 3) % (fpga_mem_pkg::RAM_WORDS / 2);
    endfunction

    function automatic logic [63:0] model_line(input logic [31:0] addr);
        if (ref_mem.exists(line_key(addr))) begin
            return ref_mem[line_key(addr)];
        end
        return '0;
    endfunction

    task automatic wait_ready(output bit ok);
        int n;
        n  = 0;
        ok = 1'b1;
        while (!bmem_ready && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!bmem_ready) begin
            $display("Timeout: bmem_ready stayed low for %0d cycles", WAIT_LIMIT);
            timed_out = 1'b1;
            ok = 1'b0;
        end
    endtask

    // Called right after the edge that accepted a read
    task automatic collect_read(input logic [31:0] addr, input logic [63:0] exp_line);
        int lat;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!bmem_rvalid && lat < WAIT_LIMIT);
        if (!bmem_rvalid) begin
            $display("Timeout: no bmem_rvalid within %0d cycles of the read", WAIT_LIMIT);
            timed_out = 1'b1;
        end else begin
            check("read_latency", 64'(READ_LAT), 64'(lat));
            check("bmem_raddr", 64'(addr), 64'(bmem_raddr));
            check("bmem_rdata", exp_line, bmem_rdata);
            @(negedge clk);
            check("bmem_rvalid", 64'(1'b0), 64'(bmem_rvalid));
            check("bmem_ready", 64'(1'b1), 64'(bmem_ready));
        end
    endtask

    task automatic run_read(input logic [31:0] addr, input logic [63:0] exp_line);
        bit ok;
        wait_ready(ok);
        if (ok) begin
            @(posedge clk);
            bmem_addr <= addr;
            bmem_read <= 1'b1;
            @(posedge clk);
            bmem_read <= 1'b0;
            collect_read(addr, exp_line);
        end
    endtask

    // Waits for bmem_ready after a write and counts rvalid pulses on the way
    task automatic finish_write(output int pulses);
        int lat;
        lat    = 0;
        pulses = 0;
        do begin
            @(negedge clk);
            lat++;
            if (bmem_rvalid) begin
                pulses++;
            end
        end while (!bmem_ready && lat < WAIT_LIMIT);
        if (!bmem_ready) begin
            $display("Timeout: write did not complete within %0d cycles", WAIT_LIMIT);
            timed_out = 1'b1;
        end else begin
            check("write_latency", 64'(WRITE_LAT), 64'(lat));
        end
    endtask

    task automatic run_write(input logic [31:0] addr, input logic [63:0] data);
        bit ok;
        int pulses;
        wait_ready(ok);
        if (ok) begin
            @(posedge clk);
            bmem_addr  <= addr;
            bmem_wdata <= data;
            bmem_write <= 1'b1;
            @(posedge clk);
            bmem_write <= 1'b0;
            ref_mem[line_key(addr)] = data;
            finish_write(pulses);
            check("rvalid_during_write", 64'(0), 64'(pulses));
        end
    endtask

    // Write, with a read of the same line held high through the busy period
    task automatic run_busy(input logic [31:0] addr, input logic [63:0] data);
        bit ok;
        int pulses;
        int extra;
        int low;
        wait_ready(ok);
        if (ok) begin
            @(posedge clk);
            bmem_addr  <= addr;
            bmem_wdata <= data;
            bmem_write <= 1'b1;
            @(posedge clk);
            bmem_write <= 1'b0;
            bmem_read  <= 1'b1;
            ref_mem[line_key(addr)] = data;
            finish_write(pulses);
            check("rvalid_while_busy", 64'(0), 64'(pulses));
            if (!timed_out) begin
                // Held read is taken on this edge
                @(posedge clk);
                bmem_read <= 1'b0;
                collect_read(addr, data);
                extra = 0;
                low   = 0;
                repeat (2 * READ_LAT) begin
                    @(negedge clk);
                    if (bmem_rvalid) begin
                        extra++;
                    end
                    if (!bmem_ready) begin
                        low++;
                    end
                end
                check("rvalid_extra_pulses", 64'(0), 64'(extra));
                check("ready_low_cycles", 64'(0), 64'(low));
            end
        end
    endtask

    task automatic report_case(input int idx, input logic [7:0] op,
                               input logic [31:0] addr, input int err_before);
        if (errors == err_before && !timed_out) begin
            passed_cases++;
            $display("case %0d %c addr=%08h pass", idx, op, addr);
        end else begin
            failed_cases++;
            $display("case %0d %c addr=%08h fail", idx, op, addr);
        end
    endtask

    initial begin
        string       line;
        int          fd;
        int          n;
        int          idx;
        int          err_before;
        logic [7:0]  op;
        logic [31:0] addr;
        logic [63:0] data;
        logic [31:0] rnd;

        seed         = 32'h6808;
        errors       = 0;
        passed_cases = 0;
        failed_cases = 0;
        timed_out    = 1'b0;
        rst          = 1'b1;
        bmem_addr    = '0;
        bmem_read    = 1'b0;
        bmem_write   = 1'b0;
        bmem_wdata   = '0;

        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        err_before = errors;
        check("bmem_ready", 64'(1'b1), 64'(bmem_ready));
        check("bmem_rvalid", 64'(1'b0), 64'(bmem_rvalid));
        report_case(0, "Z", 32'h0, err_before);

        idx = 0;
        fd  = $fopen(CASES_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the cases file %s", CASES_FILE);
            failed_cases++;
        end else begin
            while (!$feof(fd) && !timed_out) begin
                n = $fgets(line, fd);
                if (n == 0 || line.len() < 3 || line.getc(0) == "#") begin
                    continue;
                end
                n = $sscanf(line, "%c %h %h", op, addr, data);
                idx++;
                err_before = errors;
                if (n != 3) begin
                    $display("Malformed line in the cases file: %s", line);
                    errors++;
                end else if (op == "W") begin
                    run_write(addr, data);
                end else if (op == "R") begin
                    run_read(addr, data);
                end else if (op == "B") begin
                    run_busy(addr, data);
                end else if (op == "N") begin
                    rnd  = $random(seed);
                    addr = $random(seed) & 32'h0000_01ff;
                    data = {$random(seed), $random(seed)};
                    if (rnd[0]) begin
                        run_read(addr, model_line(addr));
                    end else begin
                        run_write(addr, data);
                    end
                end else begin
                    $display("Unknown operation %c in the cases file", op);
                    errors++;
                end
                report_case(idx, op, addr, err_before);
            end
            $fclose(fd);
        end

        $display("cases passed %0d failed %0d, check errors %0d",
                 passed_cases, failed_cases, errors);
        if (failed_cases == 0 && errors == 0 && !timed_out && idx > 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
